//--- Makefile
TOP = tb_kernel_mxu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wall -Wno-fatal -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f *.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 -f compile.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "Run failed, see sim.log"; \
		exit 1; \
	elif ! grep -q "Simulation PASSED" sim.log; then \
		echo "Run ended without a result, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- compile.f
mxu_pkg.sv
mxu_pe.sv
mxu_skew.sv
mxu_array.sv
mxu_wrapper.sv
mxu_checker.sv
tb_kernel_mxu.sv

//--- mxu_array.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_array #(
    parameter int K     = 3,
    parameter int M     = 4,
    parameter int ACC_W = 11
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [K*mxu_pkg::data_w-1:0] x_skewed,
    input  logic [K-1:0]                 mode_skewed,
    input  logic                         weight_load,
    input  logic [K*mxu_pkg::data_w-1:0] weight,
    output logic [M*ACC_W-1:0]           col_sum
);

    localparam int dw = mxu_pkg::data_w;

    ////////////////////////////////////////////////////////////
    // Links between cells
    ////////////////////////////////////////////////////////////

    // Row links, slot 0 is the left edge of the grid
    mxu_pkg::lane_word_t x_link    [K][M+1];
    logic                mode_link [K][M+1];
    logic [dw-1:0]       w_link    [K][M+1];

    // Column links, slot 0 is the top edge
    logic [ACC_W-1:0]    psum_link [K+1][M];

    // Left edge takes the skewed lanes and the new weight vector
    for (genvar k = 0; k < K; k++) begin : g_left
        assign x_link[k][0]    = x_skewed[k*dw +: dw];
        assign mode_link[k][0] = mode_skewed[k];
        assign w_link[k][0]    = weight[k*dw +: dw];
    end

    // Zero enters the top row, bottom row is the column result
    for (genvar m = 0; m < M; m++) begin : g_edge
        assign psum_link[0][m]            = '0;
        assign col_sum[m*ACC_W +: ACC_W] = psum_link[K][m];
    end

    ////////////////////////////////////////////////////////////
    // Cell grid
    ////////////////////////////////////////////////////////////

    // One load shifts every row right by one column
    for (genvar k = 0; k < K; k++) begin : g_row
        for (genvar m = 0; m < M; m++) begin : g_col
            mxu_pe #(
                .ACC_W (ACC_W)
            ) u_pe (
                .clk      (clk),
                .rst      (rst),
                .x_in     (x_link[k][m]),
                .mode_in  (mode_link[k][m]),
                .psum_in  (psum_link[k][m]),
                .w_load   (weight_load),
                .w_in     (w_link[k][m]),
                .x_out    (x_link[k][m+1]),
                .mode_out (mode_link[k][m+1]),
                .psum_out (psum_link[k+1][m]),
                .w_out    (w_link[k][m+1])
            );
        end
    end

endmodule

`default_nettype wire

//--- mxu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_checker #(
    parameter int K     = 3,
    parameter int M     = 4,
    parameter int ACC_W = 11
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  logic [M*ACC_W-1:0] y,
    input  logic               y_valid
);

    // Number of property failures so far
    int fails = 0;

    ////////////////////////////////////////////////////////////
    // Pipeline properties
    ////////////////////////////////////////////////////////////

    // Valid pipeline comes out of reset empty
    a_reset_idle: assert property (@(posedge clk) rst |=> !y_valid)
        else begin
            $error("y_valid high in the cycle after reset");
            fails++;
        end

    // Skew, array and deskew add up to K+M cycles
    a_latency: assert property (@(posedge clk) disable iff (rst)
        y_valid == $past(enable, K + M))
        else begin
            $error("y_valid does not follow enable by K+M cycles");
            fails++;
        end

    a_known: assert property (@(posedge clk) disable iff (rst)
        y_valid |-> !$isunknown(y))
        else begin
            $error("y has unknown bits while y_valid is high");
            fails++;
        end

endmodule

bind mxu_wrapper mxu_checker #(
    .K     (K),
    .M     (M),
    .ACC_W (ACC_W)
) u_checker (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .y       (y),
    .y_valid (y_valid)
);

`default_nettype wire

//--- mxu_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_pe #(
    parameter int ACC_W = 11
) (
    input  logic                          clk,
    input  logic                          rst,
    input  mxu_pkg::lane_word_t           x_in,
    input  logic                          mode_in,
    input  logic [ACC_W-1:0]              psum_in,
    input  logic                          w_load,
    input  logic [mxu_pkg::data_w-1:0]    w_in,
    output mxu_pkg::lane_word_t           x_out,
    output logic                          mode_out,
    output logic [ACC_W-1:0]              psum_out,
    output logic [mxu_pkg::data_w-1:0]    w_out
);

    localparam int dw = mxu_pkg::data_w;

    // Stationary weight of this cell
    mxu_pkg::lane_word_t w_q;

    logic [2*dw-1:0]      full_prod;
    logic signed [dw-1:0] hi_prod;
    logic signed [dw-1:0] lo_prod;
    logic signed [dw:0]   pair_sum;
    logic [ACC_W-1:0]     prod;

    ////////////////////////////////////////////////////////////
    // Weight register
    ////////////////////////////////////////////////////////////

    // Old weight moves on to the next column during a load
    assign w_out = w_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_q <= '0;
        end else if (w_load) begin
            w_q <= w_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Product
    ////////////////////////////////////////////////////////////

    // Unsigned full-width product
    assign full_prod = x_in.full * w_q.full;

    // Signed halves, hi with hi and lo with lo
    assign hi_prod  = x_in.pair.hi * w_q.pair.hi;
    assign lo_prod  = x_in.pair.lo * w_q.pair.lo;
    assign pair_sum = hi_prod + lo_prod;

    // Extend to accumulator width, sign only matters in pair mode
    always_comb begin
        if (mode_in == mxu_pkg::mode_pair) begin
            prod = {{(ACC_W-dw-1){pair_sum[dw]}}, pair_sum};
        end else begin
            prod = {{(ACC_W-2*dw){1'b0}}, full_prod};
        end
    end

    ////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////

    // data and mode go right, the sum goes down
    always_ff @(posedge clk) begin
        if (rst) begin
            x_out    <= '0;
            mode_out <= 1'b0;
            psum_out <= '0;
        end else begin
            x_out    <= x_in;
            mode_out <= mode_in;
            psum_out <= psum_in + prod;
        end
    end

endmodule

`default_nettype wire

//--- mxu_pkg.sv
`default_nettype none

package mxu_pkg;

    ////////////////////////////////////////////////////////////
    // Lane format
    ////////////////////////////////////////////////////////////

    // Width of one lane word
    localparam int data_w = 4;

    // One signed half in pair mode
    localparam int half_w = data_w / 2;

    // Values of data_type
    localparam logic mode_full = 1'b0;
    localparam logic mode_pair = 1'b1;

    // Same lane bits, read as one unsigned value or as two signed halves
    typedef union packed {
        // Full mode, whole word unsigned
        logic [data_w-1:0] full;
        // Pair mode, hi sits in the upper bits
        struct packed {
            logic signed [half_w-1:0] hi;
            logic signed [half_w-1:0] lo;
        } pair;
    } lane_word_t;

    ////////////////////////////////////////////////////////////
    // Accumulator sizing
    ////////////////////////////////////////////////////////////

    // Full product width, growth over the rows, one sign bit
    // so that negative pair sums stay in two's complement
    function automatic int acc_width(input int rows);
        int growth;
        growth = $clog2(rows);
        return 2 * data_w + growth + 1;
    endfunction

endpackage

`default_nettype wire

//--- mxu_skew.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_skew #(
    parameter int LANES   = 3,
    parameter int WIDTH   = 5,
    parameter bit REVERSE = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [LANES*WIDTH-1:0] d,
    output logic [LANES*WIDTH-1:0] q
);

    // Forward staggers lane i by i+1 cycles
    // Reverse undoes the stagger, lane i waits LANES-1-i cycles
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        localparam int depth = REVERSE ? (LANES - 1 - i) : (i + 1);

        if (depth == 0) begin : g_pass
            // Last lane of the deskew is already aligned
            assign q[i*WIDTH +: WIDTH] = d[i*WIDTH +: WIDTH];
        end else begin : g_delay
            logic [WIDTH-1:0] stage [depth];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int s = 0; s < depth; s++) begin
                        stage[s] <= '0;
                    end
                end else begin
                    stage[0] <= d[i*WIDTH +: WIDTH];
                    for (int s = 1; s < depth; s++) begin
                        stage[s] <= stage[s-1];
                    end
                end
            end

            assign q[i*WIDTH +: WIDTH] = stage[depth-1];
        end
    end

endmodule

`default_nettype wire

//--- mxu_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_wrapper #(
    parameter  int M     = 4,
    parameter  int K     = 3,
    localparam int ACC_W = mxu_pkg::acc_width(K)
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  logic                         data_type,
    input  logic [K*mxu_pkg::data_w-1:0] input_data,
    input  logic                         weight_load,
    input  logic [K*mxu_pkg::data_w-1:0] weight,
    output logic [M*ACC_W-1:0]           y,
    output logic                         y_valid
);

    localparam int dw  = mxu_pkg::data_w;
    // Lane word plus its mode bit on top
    localparam int lw  = dw + 1;
    localparam int lat = K + M;

    logic [K*lw-1:0]    lane_in;
    logic [K*lw-1:0]    lane_skewed;
    logic [K*dw-1:0]    x_skewed;
    logic [K-1:0]       mode_skewed;
    logic [M*ACC_W-1:0] col_sum;
    logic [lat-1:0]     valid_sr;

    ////////////////////////////////////////////////////////////
    // Input skew
    ////////////////////////////////////////////////////////////

    // Idle cycles carry zero data in full mode, so they add nothing
    for (genvar k = 0; k < K; k++) begin : g_lane_in
        assign lane_in[k*lw +: lw] = enable ? {data_type, input_data[k*dw +: dw]} : '0;
    end

    mxu_skew #(
        .LANES   (K),
        .WIDTH   (lw),
        .REVERSE (1'b0)
    ) u_in_skew (
        .clk (clk),
        .rst (rst),
        .d   (lane_in),
        .q   (lane_skewed)
    );

    // Split each skewed lane back into data and mode
    for (genvar k = 0; k < K; k++) begin : g_lane_split
        assign x_skewed[k*dw +: dw] = lane_skewed[k*lw +: dw];
        assign mode_skewed[k]        = lane_skewed[k*lw + dw];
    end

    ////////////////////////////////////////////////////////////
    // Array and output deskew
    ////////////////////////////////////////////////////////////

    mxu_array #(
        .K     (K),
        .M     (M),
        .ACC_W (ACC_W)
    ) u_array (
        .clk         (clk),
        .rst         (rst),
        .x_skewed    (x_skewed),
        .mode_skewed (mode_skewed),
        .weight_load (weight_load),
        .weight      (weight),
        .col_sum     (col_sum)
    );

    // Column m leaves the array m cycles after column 0
    mxu_skew #(
        .LANES   (M),
        .WIDTH   (ACC_W),
        .REVERSE (1'b1)
    ) u_out_deskew (
        .clk (clk),
        .rst (rst),
        .d   (col_sum),
        .q   (y)
    );

    ////////////////////////////////////////////////////////////
    // Valid pipeline
    ////////////////////////////////////////////////////////////

    // Same depth as skew, array and deskew together
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[lat-2:0], enable};
        end
    end

    assign y_valid = valid_sr[lat-1];

endmodule

`default_nettype wire

//--- tb_kernel_mxu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kernel_mxu;

    localparam int M        = 4;
    localparam int K        = 3;
    localparam int dw       = mxu_pkg::data_w;
    // Product width, growth over K rows, one sign bit
    localparam int acc_w    = 2 * dw + $clog2(K) + 1;
    localparam int lat      = K + M;
    localparam int max_wait = 4 * lat;

    logic               clk;
    logic               rst;
    logic               enable;
    logic               data_type;
    logic [K*dw-1:0]    input_data;
    logic               weight_load;
    logic [K*dw-1:0]    weight;
    logic [M*acc_w-1:0] y;
    logic               y_valid;

    // Weight columns as the model tracks them
    logic [K*dw-1:0]    w_col [M];

    logic [M*acc_w-1:0] exp_q [$];
    int                 cyc_q [$];
    int                 cycle  = 0;
    int                 checks = 0;
    int                 errors = 0;
    integer             seed;

    mxu_wrapper #(
        .M (M),
        .K (K)
    ) mxu_wrapper_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .data_type   (data_type),
        .input_data  (input_data),
        .weight_load (weight_load),
        .weight      (weight),
        .y           (y),
        .y_valid     (y_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [M*acc_w-1:0] expect_y(input logic [K*dw-1:0] x,
                                                    input logic mode);
        logic [M*acc_w-1:0]  res;
        mxu_pkg::lane_word_t xa;
        mxu_pkg::lane_word_t wa;
        int                  sum;
        int                  xh;
        int                  xl;
        int                  wh;
        int                  wl;
        res = '0;
        for (int m = 0; m < M; m++) begin
            sum = 0;
            for (int k = 0; k < K; k++) begin
                xa = x[k*dw +: dw];
                wa = w_col[m][k*dw +: dw];
                if (mode == mxu_pkg::mode_pair) begin
                    // Signed halves multiply hi with hi and lo with lo
                    xh = $signed(xa.pair.hi);
                    xl = $signed(xa.pair.lo);
                    wh = $signed(wa.pair.hi);
                    wl = $signed(wa.pair.lo);
                    sum += xh * wh + xl * wl;
                end else begin
                    sum += int'(xa.full) * int'(wa.full);
                end
            end
            res[m*acc_w +: acc_w] = sum[acc_w-1:0];
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Comparison
    ////////////////////////////////////////////////////////////

    // Samples at the edge while inputs change 1 ns later
    always @(posedge clk) begin : monitor
        logic [M*acc_w-1:0] exp_y;
        int                 exp_cyc;
        if (rst) begin
            for (int m = 0; m < M; m++) begin
                w_col[m] = '0;
            end
        end else begin
            if (y_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("y_valid high with no vector in flight at cycle %0d", cycle);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_y   = exp_q.pop_front();
                    exp_cyc = cyc_q.pop_front();
                    checks++;
                    assert (cycle - exp_cyc == lat) else begin
                        $display("Result came %0d cycles after its enable instead of %0d",
                                 cycle - exp_cyc, lat);
                        errors++;
                    end
                    assert (y === exp_y) else begin
                        $display("Fail y: expected %h, got %h", exp_y, y);
                        errors++;
                    end
                end
            end
            // Every weight load moves each column one place right
            if (weight_load) begin
                for (int m = M - 1; m > 0; m--) begin
                    w_col[m] = w_col[m-1];
                end
                w_col[0] = weight;
            end
            if (enable) begin
                exp_q.push_back(expect_y(input_data, data_type));
                cyc_q.push_back(cycle);
            end
        end
        cycle++;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_weight(input logic [K*dw-1:0] vec);
        weight_load = 1'b1;
        weight      = vec;
        next_cycle();
        weight_load = 1'b0;
    endtask

    task automatic send_vector(input logic [K*dw-1:0] vec, input logic mode);
        enable     = 1'b1;
        data_type  = mode;
        input_data = vec;
        next_cycle();
        enable     = 1'b0;
    endtask

    // Leaves enable high for the caller to advance the clock
    task automatic drive_random_vector();
        logic [31:0] r;
        r          = $random(seed);
        enable     = 1'b1;
        input_data = r[K*dw-1:0];
        data_type  = r[31];
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_wait) begin
            next_cycle();
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Timed out with %0d results still missing", exp_q.size());
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          assert_fails;
        seed        = 32'haa6d_4e2c;
        rst         = 1'b1;
        enable      = 1'b0;
        data_type   = mxu_pkg::mode_full;
        input_data  = '0;
        weight_load = 1'b0;
        weight      = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet pipeline before any enable
        for (int i = 0; i < 2 * lat; i++) begin
            assert (y_valid === 1'b0) else begin
                $display("y_valid went high before the first enable");
                errors++;
            end
            next_cycle();
        end

        // Column 2 ends up with all halves at -2
        load_weight(12'h5a3);
        load_weight(12'haaa);
        load_weight(12'hf0c);
        load_weight(12'h9a6);
        send_vector(12'hfff, mxu_pkg::mode_full);
        send_vector(12'h8c1, mxu_pkg::mode_full);
        wait_drain();

        // Negative halves and the most negative case
        send_vector(12'haaa, mxu_pkg::mode_pair);
        send_vector(12'hfff, mxu_pkg::mode_pair);
        send_vector(12'h555, mxu_pkg::mode_pair);
        send_vector(12'h6a9, mxu_pkg::mode_pair);
        wait_drain();

        // Back to back stream with mixed modes
        for (int i = 0; i < 40; i++) begin
            drive_random_vector();
            next_cycle();
        end
        enable = 1'b0;
        wait_drain();

        // Random gaps between vectors
        for (int i = 0; i < 30; i++) begin
            r = $random(seed);
            if (r[0]) begin
                enable = 1'b0;
            end else begin
                drive_random_vector();
            end
            next_cycle();
        end
        enable = 1'b0;
        wait_drain();

        // Two reloads shift the matrix by two columns
        r = $random(seed);
        load_weight(r[K*dw-1:0]);
        r = $random(seed);
        load_weight(r[K*dw-1:0]);
        for (int i = 0; i < 10; i++) begin
            drive_random_vector();
            next_cycle();
        end
        enable = 1'b0;
        wait_drain();

        repeat (lat) next_cycle();
        assert_fails = mxu_wrapper_i.u_checker.fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
